/* all.f */
source/engine_pkg.sv
source/rr_arbiter.sv
source/cmd_decode.sv
source/cmd_execute.sv
source/result_credit.sv
source/engine_top.sv
test/tb_clock.sv
test/engine_tb.sv

/* run.sh */
#!/bin/sh
# Build the engine testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module engine_tb -f all.f -o engine_sim
./obj_dir/engine_sim | tee sim.log
if grep -q "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* source/cmd_decode.sv */
/*
  Decode stage of the command engine.
  Loads the accepted command word and reads it through the view its opcode selects.
  Operands come out zero-extended to the data width, one cycle after load.
*/

module cmd_decode import engine_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_i,
  input  cmd_word_u               cmd_i,
  input  logic [CLIENT_IDX_W-1:0] idx_i,
  output logic                    valid_o,
  output logic [OP_W-1:0]         op_o,
  output logic [DATA_W-1:0]       a_o,
  output logic [DATA_W-1:0]       b_o,
  output logic                    illegal_o,
  output logic [CLIENT_IDX_W-1:0] idx_o
);

  logic [OP_W-1:0]   op_d;
  logic [DATA_W-1:0] a_d;
  logic [DATA_W-1:0] b_d;
  logic              illegal_d;

  // Opcode is at the same spot in both views
  assign op_d = cmd_i.arith.opcode;

  always_comb begin
    a_d       = '0;
    b_d       = '0;
    illegal_d = 1'b0;
    unique case (op_d)
      OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
        a_d = DATA_W'(cmd_i.arith.a);
        b_d = DATA_W'(cmd_i.arith.b);
      end
      OP_SHL, OP_SHR: begin
        // Value goes on a, amount on b
        a_d = cmd_i.shift.value;
        b_d = DATA_W'(cmd_i.shift.amount);
      end
      default: illegal_d = 1'b1;
    endcase
  end

  // Stage valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= load_i;
    end
  end

  // Payload, captured on load only
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      op_o      <= op_d;
      a_o       <= a_d;
      b_o       <= b_d;
      illegal_o <= illegal_d;
      idx_o     <= idx_i;
    end
  end

endmodule : cmd_decode

/* source/cmd_execute.sv */
/*
  Execute stage of the command engine.
  Runs the decoded operation in 17 bits so the top bit can carry the carry,
  borrow or last bit shifted out. Result is registered with its tags.
*/

module cmd_execute import engine_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    valid_i,
  input  logic [OP_W-1:0]         op_i,
  input  logic [DATA_W-1:0]       a_i,
  input  logic [DATA_W-1:0]       b_i,
  input  logic                    illegal_i,
  input  logic [CLIENT_IDX_W-1:0] idx_i,
  output logic                    valid_o,
  output logic [RAW_W-1:0]        raw_o,
  output logic                    illegal_o,
  output logic [CLIENT_IDX_W-1:0] idx_o
);

  logic [RAW_W-1:0]   a_ext;
  logic [RAW_W-1:0]   b_ext;
  logic [SHAMT_W-1:0] shamt;
  logic [RAW_W-1:0]   raw_d;

  assign a_ext = {1'b0, a_i};
  assign b_ext = {1'b0, b_i};

  // Shift amount lives in the low bits of b
  assign shamt = b_i[SHAMT_W-1:0];

  always_comb begin
    raw_d = '0;
    if (!illegal_i) begin
      unique case (op_i)
        // Bit 16 is the carry out
        OP_ADD: raw_d = a_ext + b_ext;
        // Wraps past bit 15 when a < b, so bit 16 is the borrow
        OP_SUB: raw_d = a_ext - b_ext;
        OP_AND: raw_d = {1'b0, a_i & b_i};
        OP_XOR: raw_d = {1'b0, a_i ^ b_i};
        // Last bit pushed out of the 16-bit value lands in bit 16
        OP_SHL: raw_d = a_ext << shamt;
        OP_SHR: raw_d = {1'b0, a_i >> shamt};
        default: raw_d = '0;
      endcase
    end
  end

  // Stage valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Result and tags follow the valid
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      raw_o     <= raw_d;
      illegal_o <= illegal_i;
      idx_o     <= idx_i;
    end
  end

endmodule : cmd_execute

/* source/engine_pkg.sv */
/*
  Shared definitions for the command engine.
  Holds the widths, opcode values, flag positions and the command word union.
  Every RTL block takes what it needs by a wildcard import.
*/

package engine_pkg;

  // Client side
  localparam int NUM_CLIENTS  = 4;
  localparam int CLIENT_IDX_W = $clog2(NUM_CLIENTS);

  // Word widths
  localparam int CMD_W   = 32;
  localparam int DATA_W  = 16;
  localparam int RAW_W   = DATA_W + 1;
  localparam int OP_W    = 4;
  localparam int OPND_W  = 14;
  localparam int SHAMT_W = 4;

  // Credit flow toward the sink
  localparam int ENGINE_CREDITS = 4;
  localparam int CREDIT_W       = 3;

  // Flags word, illegal on top, carry at the bottom
  localparam int FLAG_W       = 3;
  localparam int FLAG_ILLEGAL = 2;
  localparam int FLAG_ZERO    = 1;
  localparam int FLAG_CARRY   = 0;

  // Opcode values, anything else is illegal
  localparam logic [OP_W-1:0] OP_ADD = 4'h0;
  localparam logic [OP_W-1:0] OP_SUB = 4'h1;
  localparam logic [OP_W-1:0] OP_AND = 4'h2;
  localparam logic [OP_W-1:0] OP_XOR = 4'h3;
  localparam logic [OP_W-1:0] OP_SHL = 4'h4;
  localparam logic [OP_W-1:0] OP_SHR = 4'h5;

  // Arithmetic view with two narrow operands
  typedef struct packed {
    logic [OP_W-1:0]   opcode;
    logic [OPND_W-1:0] a;
    logic [OPND_W-1:0] b;
  } arith_view_t;

  // Shift view, the middle byte carries nothing
  typedef struct packed {
    logic [OP_W-1:0]    opcode;
    logic [SHAMT_W-1:0] amount;
    logic [7:0]         rsvd;
    logic [DATA_W-1:0]  value;
  } shift_view_t;

  // Same 32-bit word, two readings; opcode sits in the same place in both
  typedef union packed {
    arith_view_t arith;
    shift_view_t shift;
  } cmd_word_u;

endpackage : engine_pkg

/* source/engine_top.sv */
/*
  Top level of the shared command engine.
  Four clients feed one arbiter, then decode, execute and result stages.
  A result appears three cycles after its grant, tagged with the client index.
*/

module engine_top import engine_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [NUM_CLIENTS-1:0]  req_i,
  input  logic [CMD_W-1:0]        cmd_i [NUM_CLIENTS],
  input  logic                    credit_i,
  output logic [NUM_CLIENTS-1:0]  gnt_o,
  output logic                    res_valid_o,
  output logic [DATA_W-1:0]       res_data_o,
  output logic [FLAG_W-1:0]       res_flags_o,
  output logic [CLIENT_IDX_W-1:0] res_idx_o
);

  // Arbiter to pipeline
  logic                    arb_valid;
  cmd_word_u               arb_cmd;
  logic [CLIENT_IDX_W-1:0] arb_idx;
  logic                    credit_ok;
  logic                    accept;

  // Decode to execute
  logic                    dec_valid;
  logic [OP_W-1:0]         dec_op;
  logic [DATA_W-1:0]       dec_a;
  logic [DATA_W-1:0]       dec_b;
  logic                    dec_illegal;
  logic [CLIENT_IDX_W-1:0] dec_idx;

  // Execute to result
  logic                    exe_valid;
  logic [RAW_W-1:0]        exe_raw;
  logic                    exe_illegal;
  logic [CLIENT_IDX_W-1:0] exe_idx;

  // A command moves only with a free credit
  assign accept = arb_valid & credit_ok;

  rr_arbiter rr_arbiter_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .cmd_i   (cmd_i),
    .ready_i (credit_ok),
    .gnt_o   (gnt_o),
    .valid_o (arb_valid),
    .cmd_o   (arb_cmd),
    .idx_o   (arb_idx)
  );

  cmd_decode cmd_decode_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (accept),
    .cmd_i     (arb_cmd),
    .idx_i     (arb_idx),
    .valid_o   (dec_valid),
    .op_o      (dec_op),
    .a_o       (dec_a),
    .b_o       (dec_b),
    .illegal_o (dec_illegal),
    .idx_o     (dec_idx)
  );

  cmd_execute cmd_execute_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (dec_valid),
    .op_i      (dec_op),
    .a_i       (dec_a),
    .b_i       (dec_b),
    .illegal_i (dec_illegal),
    .idx_i     (dec_idx),
    .valid_o   (exe_valid),
    .raw_o     (exe_raw),
    .illegal_o (exe_illegal),
    .idx_o     (exe_idx)
  );

  result_credit result_credit_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .credit_i    (credit_i),
    .valid_i     (exe_valid),
    .raw_i       (exe_raw),
    .illegal_i   (exe_illegal),
    .idx_i       (exe_idx),
    .credit_ok_o (credit_ok),
    .res_valid_o (res_valid_o),
    .res_data_o  (res_data_o),
    .res_flags_o (res_flags_o),
    .res_idx_o   (res_idx_o)
  );

endmodule : engine_top

/* source/result_credit.sv */
/*
  Result stage and credit counter of the command engine.
  The counter starts full, drops on each accept and climbs on each returned credit.
  Results leave registered with data, flags and the client index.
*/

module result_credit import engine_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    accept_i,
  input  logic                    credit_i,
  input  logic                    valid_i,
  input  logic [RAW_W-1:0]        raw_i,
  input  logic                    illegal_i,
  input  logic [CLIENT_IDX_W-1:0] idx_i,
  output logic                    credit_ok_o,
  output logic                    res_valid_o,
  output logic [DATA_W-1:0]       res_data_o,
  output logic [FLAG_W-1:0]       res_flags_o,
  output logic [CLIENT_IDX_W-1:0] res_idx_o
);

  logic [CREDIT_W-1:0] credit_q;
  logic [CREDIT_W-1:0] credit_d;
  logic [DATA_W-1:0]   data_d;
  logic [FLAG_W-1:0]   flags_d;

  // Accept and return in one cycle cancel out
  always_comb begin
    credit_d = credit_q;
    unique case ({accept_i, credit_i})
      2'b10:   credit_d = credit_q - 1'b1;
      2'b01:   credit_d = credit_q + 1'b1;
      default: credit_d = credit_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CREDIT_W'(ENGINE_CREDITS);
    end else begin
      credit_q <= credit_d;
    end
  end

  // Ready toward the arbiter
  assign credit_ok_o = (credit_q != '0);

  // Low half is the data
  assign data_d = raw_i[DATA_W-1:0];

  always_comb begin
    flags_d               = '0;
    flags_d[FLAG_ILLEGAL] = illegal_i;
    flags_d[FLAG_ZERO]    = (data_d == '0);
    flags_d[FLAG_CARRY]   = raw_i[RAW_W-1];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= valid_i;
    end
  end

  // Output payload
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_data_o  <= data_d;
      res_flags_o <= flags_d;
      res_idx_o   <= idx_i;
    end
  end

endmodule : result_credit

/* source/rr_arbiter.sv */
/*
  Four-way round-robin arbiter for the command clients.
  A prefix-or chain over the masked requests finds the winner in one cycle.
  The winner is held while ready_i is low and granted first once it rises.
*/

module rr_arbiter import engine_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [NUM_CLIENTS-1:0]  req_i,
  input  logic [CMD_W-1:0]        cmd_i [NUM_CLIENTS],
  input  logic                    ready_i,
  output logic [NUM_CLIENTS-1:0]  gnt_o,
  output logic                    valid_o,
  output logic [CMD_W-1:0]        cmd_o,
  output logic [CLIENT_IDX_W-1:0] idx_o
);

  logic [NUM_CLIENTS-1:0] mask_q;
  logic [NUM_CLIENTS-1:0] mask_d;
  logic [NUM_CLIENTS-1:0] masked_req;
  logic [NUM_CLIENTS-1:0] arb_req;
  logic [NUM_CLIENTS-1:0] ppc_out;
  logic [NUM_CLIENTS-1:0] winner;

  // Only clients above the last winner take part
  assign masked_req = mask_q & req_i;

  // Wrap around to the raw requests when nobody is left above
  assign arb_req = (|masked_req) ? masked_req : req_i;

  // Prefix-or chain, synthesis folds it into a log-depth tree
  always_comb begin
    ppc_out[0] = arb_req[0];
    for (int i = 1; i < NUM_CLIENTS; i++) begin
      ppc_out[i] = ppc_out[i-1] | arb_req[i];
    end
  end

  // First set bit of the prefix is the winner
  assign winner = ppc_out ^ {ppc_out[NUM_CLIENTS-2:0], 1'b0};

  assign valid_o = |req_i;

  // Grant only when the pipeline takes the command
  assign gnt_o = (valid_o && ready_i) ? winner : '0;

  // Winner payload, one-hot select
  always_comb begin
    cmd_o = '0;
    idx_o = '0;
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      if (winner[i]) begin
        cmd_o = cmd_i[i];
        idx_o = CLIENT_IDX_W'(i);
      end
    end
  end

  // Mask update
  always_comb begin
    mask_d = mask_q;
    if (valid_o && ready_i) begin
      // Move past the winner
      mask_d = {ppc_out[NUM_CLIENTS-2:0], 1'b0};
    end else if (valid_o) begin
      // Stalled, keep the winner at the front
      mask_d = ppc_out;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
    end else begin
      mask_q <= mask_d;
    end
  end

endmodule : rr_arbiter

/* test/engine_tb.sv */
/*
  Testbench for the shared command engine.
  Four random clients and a credit sink with stalls drive the DUT; a reference model
  and concurrent assertions check data, flags, order, arbitration and credit flow.
*/

module engine_tb import engine_pkg::*;;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CMDS_PER_CLIENT = 40;
  localparam int WARM_CMDS       = 12;
  localparam int GRANT_TIMEOUT   = 1000;
  localparam int DRAIN_TIMEOUT   = 2000;
  localparam int RESET_TIMEOUT   = 20;

  logic                    clk_i;
  logic                    rst_ni;
  logic [NUM_CLIENTS-1:0]  req_i = '0;
  logic [CMD_W-1:0]        cmd_i [NUM_CLIENTS] = '{default: '0};
  logic                    credit_i = 1'b0;
  logic [NUM_CLIENTS-1:0]  gnt_o;
  logic                    res_valid_o;
  logic [DATA_W-1:0]       res_data_o;
  logic [FLAG_W-1:0]       res_flags_o;
  logic [CLIENT_IDX_W-1:0] res_idx_o;

  integer seed = 32'h51f6;
  int     data_errs = 0;
  int     order_errs = 0;
  int     arb_errs = 0;
  int     credit_errs = 0;
  int     proto_errs = 0;
  int     timeouts = 0;

  // Reference state updated on every rising edge
  logic                    rst_q;
  logic [2:0]              acc_pipe;
  logic [FLAG_W+DATA_W-1:0] exp_pipe [3];
  logic [CLIENT_IDX_W-1:0] idx_pipe [3];
  logic [CLIENT_IDX_W-1:0] last_idx;
  logic [CLIENT_IDX_W-1:0] held_idx;
  logic                    held_valid;
  logic                    full_since;
  logic                    credit_seen;
  int                      outstanding;
  int                      early_grants;
  int                      credit_model;
  int                      pending;
  int                      credit_delay;
  logic [CLIENT_IDX_W-1:0] gnt_idx;
  logic [CLIENT_IDX_W-1:0] exp_winner;

  tb_clock tb_clock_inst (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  engine_top engine_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .cmd_i       (cmd_i),
    .credit_i    (credit_i),
    .gnt_o       (gnt_o),
    .res_valid_o (res_valid_o),
    .res_data_o  (res_data_o),
    .res_flags_o (res_flags_o),
    .res_idx_o   (res_idx_o)
  );

  // Opcode rules applied to a raw command word give {illegal, zero, carry, data}
  function automatic logic [FLAG_W+DATA_W-1:0] expect_result(input logic [CMD_W-1:0] cmd);
    logic [DATA_W:0] raw;
    logic            illegal;
    raw     = '0;
    illegal = 1'b0;
    case (cmd[31:28])
      OP_ADD:  raw = 17'(cmd[27:14]) + 17'(cmd[13:0]);
      OP_SUB:  raw = 17'(cmd[27:14]) - 17'(cmd[13:0]);
      OP_AND:  raw = 17'(cmd[27:14] & cmd[13:0]);
      OP_XOR:  raw = 17'(cmd[27:14] ^ cmd[13:0]);
      OP_SHL:  raw = {1'b0, cmd[15:0]} << cmd[27:24];
      OP_SHR:  raw = 17'(cmd[15:0] >> cmd[27:24]);
      default: illegal = 1'b1;
    endcase
    return {illegal, raw[15:0] == 16'h0, raw[16], raw[15:0]};
  endfunction

  // First requester after the last winner with wrap-around
  function automatic logic [CLIENT_IDX_W-1:0] rr_next(input logic [CLIENT_IDX_W-1:0] last,
                                                      input logic [NUM_CLIENTS-1:0] req);
    logic [CLIENT_IDX_W-1:0] cand;
    for (int i = 1; i <= NUM_CLIENTS; i++) begin
      cand = last + CLIENT_IDX_W'(i);
      if (req[cand]) return cand;
    end
    return last;
  endfunction

  function automatic logic [CLIENT_IDX_W-1:0] onehot_index(input logic [NUM_CLIENTS-1:0] vec);
    logic [CLIENT_IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      if (vec[i]) idx = CLIENT_IDX_W'(i);
    end
    return idx;
  endfunction

  // Mostly legal opcodes while the rest keep whatever nibble came up
  function automatic logic [CMD_W-1:0] make_cmd();
    logic [CMD_W-1:0] word;
    logic [2:0]       pick;
    word = $random(seed);
    pick = 3'($random(seed));
    if (pick < 3'd6) word[31:28] = {1'b0, pick};
    return word;
  endfunction

  // Mostly short delays with a long stall now and then
  function automatic int pick_delay();
    int r;
    r = $random(seed) & 15;
    if (r == 0) return 30 + ($random(seed) & 15);
    return r & 3;
  endfunction

  task automatic run_client(input int k);
    int waited;
    for (int n = 0; n < CMDS_PER_CLIENT; n++) begin
      req_i[k] <= 1'b1;
      cmd_i[k] <= make_cmd();
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
      end while (!gnt_o[k] && waited < GRANT_TIMEOUT);
      if (!gnt_o[k]) begin
        $display("Timeout: client %0d was not granted within %0d cycles", k, GRANT_TIMEOUT);
        timeouts++;
        req_i[k] <= 1'b0;
        return;
      end
      // Idle gaps after warm-up so the request set keeps changing
      if (n >= WARM_CMDS && ($random(seed) & 3) == 0) begin
        req_i[k] <= 1'b0;
        repeat (1 + ($random(seed) & 3)) @(posedge clk_i);
      end
    end
    req_i[k] <= 1'b0;
  endtask

  assign gnt_idx      = onehot_index(gnt_o);
  assign credit_model = ENGINE_CREDITS - outstanding;
  assign exp_winner   = held_valid ? held_idx : rr_next(last_idx, req_i);

  // Expected results ride a 3-deep pipe from the grant edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_q        <= 1'b0;
      acc_pipe     <= '0;
      last_idx     <= CLIENT_IDX_W'(NUM_CLIENTS - 1);
      held_idx     <= '0;
      held_valid   <= 1'b0;
      full_since   <= 1'b0;
      credit_seen  <= 1'b0;
      outstanding  <= 0;
      early_grants <= 0;
    end else begin
      rst_q       <= 1'b1;
      acc_pipe    <= {acc_pipe[1:0], |gnt_o};
      exp_pipe[0] <= expect_result(cmd_i[gnt_idx]);
      exp_pipe[1] <= exp_pipe[0];
      exp_pipe[2] <= exp_pipe[1];
      idx_pipe[0] <= gnt_idx;
      idx_pipe[1] <= idx_pipe[0];
      idx_pipe[2] <= idx_pipe[1];
      outstanding <= outstanding + int'(|gnt_o) - int'(credit_i);
      full_since  <= ((|gnt_o) ? 1'b1 : full_since) & (req_i == '1);
      if (|gnt_o) begin
        last_idx   <= gnt_idx;
        held_valid <= 1'b0;
      end else if (|req_i && credit_model == 0 && !held_valid) begin
        // Winner picked during the stall must be the first one served
        held_valid <= 1'b1;
        held_idx   <= rr_next(last_idx, req_i);
      end
      if (!credit_seen && |gnt_o) early_grants <= early_grants + 1;
      if (credit_i) credit_seen <= 1'b1;
    end
  end

  // Sink returns one credit pulse per received result after a random delay
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_i     <= 1'b0;
      pending      <= 0;
      credit_delay <= 30;
    end else begin
      credit_i <= 1'b0;
      if (credit_delay != 0) begin
        credit_delay <= credit_delay - 1;
        pending      <= pending + int'(res_valid_o);
      end else if (pending != 0) begin
        credit_i     <= 1'b1;
        credit_delay <= pick_delay();
        pending      <= pending + int'(res_valid_o) - 1;
      end else begin
        pending <= pending + int'(res_valid_o);
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o |-> {res_flags_o, res_data_o} == exp_pipe[2])
    else begin
      data_errs++;
      $display("ERROR %0t: result flags/data %h/%h, expected %h", $time,
               $sampled(res_flags_o), $sampled(res_data_o), exp_pipe[2]);
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (res_valid_o && exp_pipe[2][FLAG_W+DATA_W-1]) |-> (res_data_o == '0 && res_flags_o == 3'b110))
    else begin
      data_errs++;
      $display("ERROR %0t: illegal command gave data %h flags %b", $time,
               $sampled(res_data_o), $sampled(res_flags_o));
    end

  // Three edges from grant to result with nothing in between
  assert property (@(posedge clk_i) disable iff (!rst_ni) res_valid_o == acc_pipe[2])
    else begin
      order_errs++;
      $display("ERROR %0t: res_valid_o %0b, expected %0b", $time,
               $sampled(res_valid_o), acc_pipe[2]);
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o |-> res_idx_o == idx_pipe[2])
    else begin
      order_errs++;
      $display("ERROR %0t: res_idx_o %0d, expected %0d", $time,
               $sampled(res_idx_o), idx_pipe[2]);
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rst_ni && !rst_q) |-> (gnt_o == '0 && !res_valid_o))
    else begin
      order_errs++;
      $display("ERROR %0t: outputs not idle after reset", $time);
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|req_i && credit_model != 0) |-> gnt_o == (NUM_CLIENTS'(1) << exp_winner))
    else begin
      arb_errs++;
      $display("ERROR %0t: gnt_o %b, expected client %0d", $time,
               $sampled(gnt_o), exp_winner);
    end

  // With all four requesting the whole time the grant steps by exactly one
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|gnt_o && full_since && req_i == '1) |-> gnt_idx == last_idx + 2'd1)
    else begin
      arb_errs++;
      $display("ERROR %0t: rotation broken, client %0d after %0d", $time, gnt_idx, last_idx);
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) credit_model == 0 |-> gnt_o == '0)
    else begin
      credit_errs++;
      $display("ERROR %0t: grant %b with no credit left", $time, $sampled(gnt_o));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) outstanding <= ENGINE_CREDITS)
    else begin
      credit_errs++;
      $display("ERROR %0t: %0d results outstanding", $time, outstanding);
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (credit_i && !credit_seen) |-> early_grants == ENGINE_CREDITS)
    else begin
      credit_errs++;
      $display("ERROR %0t: %0d grants before first credit, expected %0d", $time,
               early_grants, ENGINE_CREDITS);
    end

  // Clients must hold request and command until granted
  for (genvar k = 0; k < NUM_CLIENTS; k++) begin : g_hold
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (req_i[k] && !gnt_o[k]) |=> (req_i[k] && cmd_i[k] == $past(cmd_i[k])))
      else begin
        proto_errs++;
        $display("ERROR %0t: client %0d dropped or changed its request", $time, k);
      end
  end

  initial begin
    int waited;
    int total;
    waited = 0;
    while (rst_ni !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (rst_ni !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end else begin
      fork
        run_client(0);
        run_client(1);
        run_client(2);
        run_client(3);
      join
      // Let every result come back and every credit return
      waited = 0;
      while (outstanding != 0 && waited < DRAIN_TIMEOUT) begin
        @(posedge clk_i);
        waited++;
      end
      if (outstanding != 0) begin
        $display("Timeout: %0d results still outstanding at the end", outstanding);
        timeouts++;
      end
    end
    total = data_errs + order_errs + arb_errs + credit_errs + proto_errs + timeouts;
    $display("Errors: data %0d, order %0d, arbiter %0d, credit %0d, protocol %0d, timeouts %0d",
             data_errs, order_errs, arb_errs, credit_errs, proto_errs, timeouts);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : engine_tb

/* test/tb_clock.sv */
/*
  Clock and reset source for the engine testbench.
  Gives a 10 ns clock and holds the active-low reset for two rising edges.
*/

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Released on the second rising edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule : tb_clock
